//--- source/interp_settings.svh
`ifndef INTERP_SETTINGS_SVH
`define INTERP_SETTINGS_SVH

`define INTERP_WORD        16
`define INTERP_FRAC        7
`define INTERP_ADDR        8
`define INTERP_DEPTH       256

`define INTERP_M_ADDR      0
`define INTERP_T_BASE      1
`define INTERP_U_BASE      128

`define INTERP_REG_CTRL    12'h000
`define INTERP_REG_STATUS  12'h004
`define INTERP_REG_TK      12'h008
`define INTERP_REG_RADDR   12'h00c
`define INTERP_REG_RESULT  12'h010
`define INTERP_RAM_WIN     12'h400

`endif

//--- source/interp_pkg.sv
`default_nettype none
`include "interp_settings.svh"

package interp_pkg;

    // Q9.7 signed sample
    typedef logic signed [`INTERP_WORD-1:0] sample_t;
    typedef logic [`INTERP_ADDR-1:0] ram_addr_t;

    typedef enum logic [3:0] {
        st_idle,
        st_read_m,
        st_read_t,
        st_compare,
        st_read_u,
        st_sub_diff,
        st_divide,
        st_multiply,
        st_add,
        st_write_back,
        st_finish
    } interp_state_t;

endpackage

`default_nettype wire

//--- source/sample_ram.sv
`default_nettype none
`include "interp_settings.svh"

module sample_ram import interp_pkg::*; (
    input  wire logic clk,
    input  ram_addr_t addr_a,
    input  sample_t   wdata_a,
    input  wire logic we_a,
    output sample_t   rdata_a,
    input  ram_addr_t addr_b,
    input  sample_t   wdata_b,
    input  wire logic we_b,
    output sample_t   rdata_b
);

    sample_t mem [`INTERP_DEPTH];

    always_ff @(posedge clk) begin
        if (we_a)
            mem[addr_a] <= wdata_a;
        if (we_b)
            mem[addr_b] <= wdata_b;
        // write-first on each port
        rdata_a <= we_a ? wdata_a : mem[addr_a];
        rdata_b <= we_b ? wdata_b : mem[addr_b];
    end

    assert property (@(posedge clk) !(we_a && we_b && addr_a == addr_b));

endmodule

`default_nettype wire

//--- source/seq_multiplier.sv
`default_nettype none

module seq_multiplier import interp_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    input  sample_t   a,
    input  sample_t   b,
    output sample_t   product,
    output logic      done
);

    logic        running;
    logic [3:0]  cnt;
    logic        neg;
    logic [31:0] acc;
    logic [31:0] mcand;
    logic [15:0] mplier;
    logic [31:0] full;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= running && cnt == 4'd15;
            if (start && !running)
                running <= 1'b1;
            else if (running && cnt == 4'd15)
                running <= 1'b0;
        end
    end

    // magnitudes in, sign applied on the way out
    always_ff @(posedge clk) begin
        if (start && !running) begin
            cnt    <= '0;
            acc    <= '0;
            neg    <= a[15] ^ b[15];
            mcand  <= {16'b0, a[15] ? 16'(-a) : a};
            mplier <= b[15] ? 16'(-b) : b;
        end else if (running) begin
            cnt    <= cnt + 4'd1;
            acc    <= acc + (mplier[0] ? mcand : 32'd0);
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign full    = neg ? -acc : acc;
    assign product = full[22:7];

    // no new operands while a product is pending
    assert property (@(posedge clk) disable iff (reset) start |-> !running);

endmodule

`default_nettype wire

//--- source/seq_divider.sv
`default_nettype none

module seq_divider import interp_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    input  sample_t   num,
    input  sample_t   den,
    output sample_t   quotient,
    output logic      done
);

    logic        running;
    logic [3:0]  cnt;
    logic [16:0] rem;
    logic [15:0] dvd;
    logic [15:0] dsr;
    logic [16:0] trial;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= running && cnt == 4'd15;
            if (start && !running)
                running <= 1'b1;
            else if (running && cnt == 4'd15)
                running <= 1'b0;
        end
    end

    // num * 128 split into upper remainder and 16 bits left to shift in
    assign trial = {rem[15:0], dvd[15]} - {1'b0, dsr};

    always_ff @(posedge clk) begin
        if (start && !running) begin
            cnt      <= '0;
            rem      <= {8'b0, num[15:7]} >> 2;
            dvd      <= {num[8:0], 7'b0};
            dsr      <= den;
            quotient <= '0;
        end else if (running) begin
            cnt      <= cnt + 4'd1;
            dvd      <= dvd << 1;
            quotient <= {quotient[14:0], ~trial[16]};
            rem      <= trial[16] ? {rem[15:0], dvd[15]} : trial;
        end
    end

endmodule

`default_nettype wire

//--- source/interp_fsm.sv
`default_nettype none

module interp_fsm import interp_pkg::*; (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    go,
    input  wire logic    tk_lt_t,
    input  wire logic    m_small,
    input  wire logic    at_last,
    input  wire logic    mul_done,
    input  wire logic    div_done,
    output interp_state_t state,
    output logic         ld_m,
    output logic         ld_tn,
    output logic         ld_tz,
    output logic         ld_un,
    output logic         ld_uz,
    output logic         ld_diff,
    output logic         ld_k,
    output logic         ld_res,
    output logic         idx_inc,
    output logic         addr_sel,
    output logic         we_b,
    output logic         mul_start,
    output logic         div_start,
    output logic         busy,
    output logic         finish
);

    interp_state_t next;
    logic          entry;
    logic          clamp;
    logic          hit_clamp;

    // first compare sees t[0], where an exact hit also clamps
    assign hit_clamp = m_small | (entry & tk_lt_t) | (~tk_lt_t & at_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            entry <= 1'b0;
            clamp <= 1'b0;
        end else begin
            state <= next;
            entry <= (next != state);
            if (state == st_compare)
                clamp <= hit_clamp;
        end
    end

    always_comb begin
        next = state;
        case (state)
            st_idle:       if (go) next = st_read_m;
            st_read_m:     next = st_read_t;
            st_read_t:     next = st_compare;
            st_compare:    if (hit_clamp || tk_lt_t) next = st_read_u;
            st_read_u:     if (!entry) next = clamp ? st_write_back : st_sub_diff;
            st_sub_diff:   next = st_divide;
            st_divide:     if (div_done) next = st_multiply;
            st_multiply:   if (mul_done) next = st_add;
            st_add:        next = st_write_back;
            st_write_back: next = st_finish;
            default:       next = st_idle;
        endcase
    end

    assign ld_m      = (state == st_read_t);
    assign ld_tn     = (state == st_compare) && !hit_clamp && !tk_lt_t;
    assign idx_inc   = ld_tn;
    assign ld_tz     = (state == st_compare) && !hit_clamp && tk_lt_t;
    assign ld_un     = (state == st_read_u) && !entry;
    assign ld_uz     = (state == st_sub_diff);
    assign ld_diff   = ((state == st_read_u) && entry) || (state == st_divide);
    assign ld_k      = (state == st_divide) && div_done;
    // clamp takes u[idx] straight from the RAM
    assign ld_res    = (state == st_add) || (ld_un && clamp);
    assign addr_sel  = (state == st_read_u) && entry && !clamp;
    assign we_b      = (state == st_write_back);
    assign div_start = (state == st_sub_diff);
    assign mul_start = (state == st_multiply) && entry;
    assign busy      = (state != st_idle);
    assign finish    = (state == st_finish);

endmodule

`default_nettype wire

//--- source/interp_unit.sv
`default_nettype none
`include "interp_settings.svh"

module interp_unit import interp_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic go,
    input  sample_t   tk,
    input  ram_addr_t result_addr,
    output ram_addr_t addr_b,
    output sample_t   wdata_b,
    output logic      we_b,
    input  sample_t   rdata_b,
    output logic      busy,
    output logic      finish,
    output sample_t   result,
    output logic      overflow
);

    interp_state_t state;
    logic ld_m, ld_tn, ld_tz, ld_un, ld_uz, ld_diff, ld_k, ld_res;
    logic idx_inc, addr_sel, mul_start, div_start, mul_done, div_done;
    logic tk_lt_t, m_small, at_last;
    sample_t   m_q, tn, tz, un, uz, diff, k, prod, quot;
    sample_t   op_a, op_b;
    logic      op_sub;
    logic [16:0] alu;
    ram_addr_t idx;

    always_comb begin
        op_a   = '0;
        op_b   = '0;
        op_sub = 1'b1;
        case (state)
            st_compare: begin
                op_a = tk;
                op_b = rdata_b;
            end
            st_read_u: begin
                op_a = tk;
                op_b = tn;
            end
            st_sub_diff: begin
                op_a = tz;
                op_b = tn;
            end
            st_divide: begin
                op_a = uz;
                op_b = un;
            end
            st_add: begin
                op_a   = un;
                op_b   = prod;
                op_sub = 1'b0;
            end
            default: ;
        endcase
    end

    // one shared adder/subtractor with a guard bit
    assign alu = op_sub ? {op_a[15], op_a} - {op_b[15], op_b}
                        : {op_a[15], op_a} + {op_b[15], op_b};

    assign tk_lt_t = alu[16] | ((idx == '0) && (alu == '0));
    assign m_small = ($unsigned(m_q) <= 16'd1);
    assign at_last = ({8'b0, idx} == m_q - 16'sd1);

    always_comb begin
        case (state)
            st_read_m:     addr_b = ram_addr_t'(`INTERP_M_ADDR);
            st_read_t:     addr_b = ram_addr_t'(`INTERP_T_BASE) + idx;
            st_compare:    addr_b = ram_addr_t'(`INTERP_T_BASE) + idx + 8'd1;
            st_write_back: addr_b = result_addr;
            default:       addr_b = ram_addr_t'(`INTERP_U_BASE) + idx - {7'b0, addr_sel};
        endcase
    end

    assign wdata_b = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            idx      <= '0;
            overflow <= 1'b0;
        end else if (go) begin
            idx      <= '0;
            overflow <= 1'b0;
        end else begin
            if (idx_inc)
                idx <= idx + 8'd1;
            if (ld_diff && state == st_divide)
                overflow <= alu[16] ^ alu[15];
        end
    end

    always_ff @(posedge clk) begin
        if (ld_m)    m_q    <= rdata_b;
        if (ld_tn)   tn     <= rdata_b;
        if (ld_tz)   tz     <= rdata_b;
        if (ld_un)   un     <= rdata_b;
        if (ld_uz)   uz     <= rdata_b;
        if (ld_diff) diff   <= alu[15:0];
        if (ld_k)    k      <= quot;
        if (ld_res)  result <= (state == st_add) ? alu[15:0] : rdata_b;
    end

    interp_fsm u_fsm (
        .clk, .reset, .go, .tk_lt_t, .m_small, .at_last, .mul_done, .div_done,
        .state, .ld_m, .ld_tn, .ld_tz, .ld_un, .ld_uz, .ld_diff, .ld_k, .ld_res,
        .idx_inc, .addr_sel, .we_b, .mul_start, .div_start, .busy, .finish
    );

    seq_multiplier u_mul (
        .clk, .reset, .start(mul_start), .a(diff), .b(k), .product(prod), .done(mul_done)
    );

    seq_divider u_div (
        .clk, .reset, .start(div_start), .num(diff), .den(alu[15:0]),
        .quotient(quot), .done(div_done)
    );

    // arithmetic answers land only in the state waiting for them
    assert property (@(posedge clk) disable iff (reset) div_done |-> state == st_divide);
    assert property (@(posedge clk) disable iff (reset) mul_done |-> state == st_multiply);

endmodule

`default_nettype wire

//--- source/interp_apb_regs.sv
`default_nettype none
`include "interp_settings.svh"

module interp_apb_regs import interp_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [11:0] paddr,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             go,
    output sample_t          tk,
    output ram_addr_t        result_addr,
    input  wire logic        busy,
    input  wire logic        finish,
    input  sample_t          result,
    input  wire logic        overflow,
    output ram_addr_t        addr_a,
    output sample_t          wdata_a,
    output logic             we_a,
    input  sample_t          rdata_a,
    output logic             irq
);

    logic    access;
    logic    win;
    logic    reg_hit;
    logic    ram_rd;
    logic    rd_wait;
    logic    wr_reg;
    logic    done_q;
    logic    ovf_q;
    sample_t result_q;

    assign access  = psel & penable;
    assign win     = (paddr >= `INTERP_RAM_WIN) && (paddr < `INTERP_RAM_WIN + 4 * `INTERP_DEPTH);
    assign reg_hit = (paddr == `INTERP_REG_CTRL) || (paddr == `INTERP_REG_STATUS) ||
                     (paddr == `INTERP_REG_TK) || (paddr == `INTERP_REG_RADDR) ||
                     (paddr == `INTERP_REG_RESULT);

    // synchronous RAM read needs one wait state
    assign ram_rd  = win & ~pwrite & ~busy;
    assign pready  = access & (~ram_rd | rd_wait);
    assign pslverr = access & (win ? busy : ~reg_hit);

    assign addr_a  = paddr[`INTERP_ADDR+1:2];
    assign wdata_a = pwdata[`INTERP_WORD-1:0];
    assign we_a    = access & pwrite & win & ~busy;

    assign wr_reg  = access & pwrite & reg_hit;
    assign go      = wr_reg & (paddr == `INTERP_REG_CTRL) & pwdata[0] & ~busy;
    assign irq     = done_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_wait     <= 1'b0;
            tk          <= '0;
            result_addr <= '0;
            done_q      <= 1'b0;
            ovf_q       <= 1'b0;
        end else begin
            rd_wait <= access & ram_rd & ~rd_wait;
            if (wr_reg && paddr == `INTERP_REG_TK)
                tk <= pwdata[`INTERP_WORD-1:0];
            if (wr_reg && paddr == `INTERP_REG_RADDR)
                result_addr <= pwdata[`INTERP_ADDR-1:0];
            if (go) begin
                done_q <= 1'b0;
                ovf_q  <= 1'b0;
            end else if (finish) begin
                done_q <= 1'b1;
                ovf_q  <= overflow;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (finish)
            result_q <= result;
    end

    always_comb begin
        prdata = '0;
        if (win)
            prdata = {16'b0, rdata_a};
        else if (paddr == `INTERP_REG_STATUS)
            prdata = {29'b0, ovf_q, done_q, busy};
        else if (paddr == `INTERP_REG_TK)
            prdata = {16'b0, tk};
        else if (paddr == `INTERP_REG_RADDR)
            prdata = {24'b0, result_addr};
        else if (paddr == `INTERP_REG_RESULT)
            prdata = {16'b0, result_q};
    end

    // engine must pick up every start
    assert property (@(posedge clk) disable iff (reset) go |=> busy);

endmodule

`default_nettype wire

//--- source/interp_top.sv
`default_nettype none

module interp_top import interp_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [11:0] paddr,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             irq
);

    logic      go, busy, finish, overflow, we_a, we_b;
    sample_t   tk, result, wdata_a, rdata_a, wdata_b, rdata_b;
    ram_addr_t result_addr, addr_a, addr_b;

    interp_apb_regs u_regs (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .go, .tk, .result_addr, .busy, .finish, .result, .overflow,
        .addr_a, .wdata_a, .we_a, .rdata_a, .irq
    );

    interp_unit u_unit (
        .clk, .reset, .go, .tk, .result_addr,
        .addr_b, .wdata_b, .we_b, .rdata_b,
        .busy, .finish, .result, .overflow
    );

    sample_ram u_ram (
        .clk,
        .addr_a, .wdata_a, .we_a, .rdata_a,
        .addr_b, .wdata_b, .we_b, .rdata_b
    );

endmodule

`default_nettype wire

//--- dv/interp_checker.sv
`default_nettype none
`include "interp_settings.svh"

module interp_checker import interp_pkg::*; (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        psel,
    input wire logic        penable,
    input wire logic        pwrite,
    input wire logic [11:0] paddr,
    input wire logic [31:0] pwdata,
    input wire logic [31:0] prdata,
    input wire logic        pready,
    input wire logic        pslverr,
    input wire logic        irq
);

    timeunit 1ns;
    timeprecision 100ps;

    string       test_name = "none";
    int          error_count = 0;
    sample_t     model [`INTERP_DEPTH];
    logic        known [`INTERP_DEPTH];
    sample_t     tk_q;
    ram_addr_t   raddr_q;
    sample_t     exp_result;
    logic        exp_ovf;
    logic        started;
    logic        fresh;
    logic        win;
    ram_addr_t   word;
    logic [16:0] ref_out;
    int          j;

    // returns {overflow, result} for the table held in the model
    function automatic logic [16:0] interpolate(input sample_t tk_v);
        int      m;
        int      n;
        int      i;
        int      k;
        int      dt;
        int      p;
        sample_t dw;
        logic    ovf;
        m = int'($unsigned(model[`INTERP_M_ADDR]));
        if (m <= 1 || tk_v <= model[`INTERP_T_BASE])
            return {1'b0, model[`INTERP_U_BASE]};
        if (tk_v >= model[`INTERP_T_BASE + m - 1])
            return {1'b0, model[`INTERP_U_BASE + m - 1]};
        n = 0;
        for (i = 1; i < m - 1; i++)
            if (model[`INTERP_T_BASE + i] <= tk_v)
                n = i;
        k = ((int'(tk_v) - int'(model[`INTERP_T_BASE + n])) * 128) /
            (int'(model[`INTERP_T_BASE + n + 1]) - int'(model[`INTERP_T_BASE + n]));
        dt = int'(model[`INTERP_U_BASE + n + 1]) - int'(model[`INTERP_U_BASE + n]);
        ovf = (dt > 32767) || (dt < -32768);
        dw = sample_t'(dt);
        // arithmetic shift floors toward minus infinity
        p = (int'(dw) * k) >>> 7;
        return {ovf, sample_t'(int'(model[`INTERP_U_BASE + n]) + p)};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: %s expected %h actual %h", test_name, what,
                     expected, actual);
        end
    endtask

    assign win  = (paddr >= `INTERP_RAM_WIN);
    assign word = paddr[`INTERP_ADDR+1:2];

    // transfers are sampled mid-cycle, once the access phase is complete
    always @(negedge clk) begin
        if (reset) begin
            started = 1'b0;
            fresh   = 1'b0;
            for (j = 0; j < `INTERP_DEPTH; j++)
                known[j] = 1'b0;
        end else if (psel && penable && pready && !pslverr) begin
            if (pwrite) begin
                if (win) begin
                    model[word] = pwdata[15:0];
                    known[word] = 1'b1;
                end else if (paddr == `INTERP_REG_TK) begin
                    tk_q = pwdata[15:0];
                end else if (paddr == `INTERP_REG_RADDR) begin
                    raddr_q = pwdata[7:0];
                end else if (paddr == `INTERP_REG_CTRL && pwdata[0]) begin
                    ref_out        = interpolate(tk_q);
                    exp_ovf        = ref_out[16];
                    exp_result     = ref_out[15:0];
                    model[raddr_q] = exp_result;
                    known[raddr_q] = 1'b1;
                    started        = 1'b1;
                    fresh          = 1'b1;
                end
            end else if (win) begin
                if (known[word])
                    compare_value("ram word", {16'h0, model[word]}, prdata);
            end else if (paddr == `INTERP_REG_RESULT && started) begin
                compare_value("result", {16'h0, exp_result}, prdata);
            end else if (paddr == `INTERP_REG_STATUS) begin
                if (!started) begin
                    compare_value("status", 32'h0, prdata);
                    compare_value("irq", 32'h0, {31'h0, irq});
                end else if (fresh) begin
                    // start clears done, engine still running
                    compare_value("status", 32'h1, prdata);
                    compare_value("irq", 32'h0, {31'h0, irq});
                    fresh = 1'b0;
                end else begin
                    compare_value("status", {29'h0, exp_ovf, 2'b10}, prdata);
                    compare_value("irq", 32'h1, {31'h0, irq});
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/interp_tb.sv
`default_nettype none
`include "interp_settings.svh"

module interp_tb import interp_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_queries = 52;

    logic        clk = 1'b0;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;
    integer      seed = 32'hafc8c7dd;
    int          tb_errors = 0;
    int          m_tab;
    sample_t     t_tab [16];
    sample_t     u_tab [16];

    interp_top dut (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .irq
    );

    interp_checker u_checker (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .irq
    );

    always #10 clk = ~clk;

    function automatic logic [11:0] win_addr(input int a);
        return 12'(`INTERP_RAM_WIN + 4 * a);
    endfunction

    function automatic logic [31:0] fill_word(input int a);
        return {16'h0, 8'(a) ^ 8'h5a, 8'(a)};
    endfunction

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] data, input logic exp_err);
        int waits;
        int exp_waits;
        // only a RAM read that is let through needs a wait state
        exp_waits = (!write && addr >= `INTERP_RAM_WIN && !exp_err) ? 1 : 0;
        waits = 0;
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        if (pslverr !== exp_err) begin
            tb_errors++;
            $display("[ERROR] %s: pslverr at %h expected %b actual %b",
                     u_checker.test_name, addr, exp_err, pslverr);
        end
        if (waits != exp_waits) begin
            tb_errors++;
            $display("[ERROR] %s: wait states at %h expected %0d actual %0d",
                     u_checker.test_name, addr, exp_waits, waits);
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        apb_access(1'b1, addr, data, exp_err);
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic exp_err);
        apb_access(1'b0, addr, 32'h0, exp_err);
    endtask

    task automatic set_point(input int i, input int t, input int u);
        t_tab[i] = sample_t'(t);
        u_tab[i] = sample_t'(u);
    endtask

    task automatic load_table();
        int i;
        apb_write(win_addr(`INTERP_M_ADDR), 32'(m_tab), 1'b0);
        for (i = 0; i < m_tab; i++) begin
            apb_write(win_addr(`INTERP_T_BASE + i), {16'h0, t_tab[i]}, 1'b0);
            apb_write(win_addr(`INTERP_U_BASE + i), {16'h0, u_tab[i]}, 1'b0);
        end
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!irq && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if (!irq) begin
            tb_errors++;
            $display("%s: engine did not raise irq within 400 cycles", u_checker.test_name);
        end
    endtask

    task automatic start_query(input int tk_v, input int raddr);
        apb_write(`INTERP_REG_TK, 32'(tk_v) & 32'hffff, 1'b0);
        apb_write(`INTERP_REG_RADDR, 32'(raddr), 1'b0);
        apb_write(`INTERP_REG_CTRL, 32'h1, 1'b0);
        apb_read(`INTERP_REG_STATUS, 1'b0);
    endtask

    task automatic finish_query(input int raddr);
        wait_done();
        apb_read(`INTERP_REG_STATUS, 1'b0);
        apb_read(`INTERP_REG_RESULT, 1'b0);
        apb_read(win_addr(raddr), 1'b0);
    endtask

    task automatic run_query(input int tk_v, input int raddr);
        start_query(tk_v, raddr);
        finish_query(raddr);
    endtask

    initial begin
        int i;
        int q;
        int span;
        int tk_v;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        u_checker.test_name = "reset_state";
        apb_read(`INTERP_REG_STATUS, 1'b0);
        apb_read(12'h020, 1'b1);
        u_checker.test_name = "ram_window";
        for (i = 240; i < 248; i++)
            apb_write(win_addr(i), fill_word(i), 1'b0);
        for (i = 240; i < 248; i++)
            apb_read(win_addr(i), 1'b0);

        // breakpoints -5, -1, 2, 3, 10 in Q9.7
        u_checker.test_name = "interior";
        m_tab = 5;
        set_point(0, -640, 100);
        set_point(1, -128, 1000);
        set_point(2, 256, -500);
        set_point(3, 384, 2000);
        set_point(4, 1280, 300);
        load_table();
        run_query(-400, 200);
        run_query(0, 201);
        run_query(300, 202);
        run_query(1000, 203);

        u_checker.test_name = "clamp";
        run_query(-1000, 204);
        run_query(-640, 205);
        run_query(1280, 206);
        run_query(2000, 207);
        run_query(256, 208);
        u_checker.test_name = "single_point";
        apb_write(win_addr(`INTERP_M_ADDR), 32'd1, 1'b0);
        run_query(500, 209);

        u_checker.test_name = "overflow";
        m_tab = 2;
        set_point(0, 0, -30000);
        set_point(1, 1024, 30000);
        load_table();
        run_query(512, 210);

        for (q = 0; q < 40; q++) begin
            u_checker.test_name = $sformatf("random_%0d", q);
            m_tab = 2 + ($random(seed) & 7);
            t_tab[0] = sample_t'(-($random(seed) & 4095));
            for (i = 1; i < m_tab; i++)
                t_tab[i] = t_tab[i - 1] + sample_t'(1 + ($random(seed) & 1023));
            for (i = 0; i < m_tab; i++)
                u_tab[i] = sample_t'($random(seed));
            load_table();
            // queries reach a little past both ends of the table
            span = int'(t_tab[m_tab - 1]) - int'(t_tab[0]) + 128;
            tk_v = int'(t_tab[0]) - 64 + (($random(seed) & 32'h7fffffff) % span);
            run_query(tk_v, 160 + q);
        end

        u_checker.test_name = "busy_access";
        m_tab = 2;
        set_point(0, 0, -100);
        set_point(1, 1024, 900);
        load_table();
        start_query(300, 211);
        apb_write(win_addr(`INTERP_T_BASE + 1), 32'h7777, 1'b1);
        apb_read(win_addr(`INTERP_T_BASE + 1), 1'b1);
        finish_query(211);
        apb_read(win_addr(`INTERP_T_BASE + 1), 1'b0);

        $display("errors: checker %0d, testbench %0d", u_checker.error_count, tb_errors);
        if (u_checker.error_count == 0 && tb_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        repeat (num_queries * 600 + 5000) @(posedge clk);
        $display("timeout: run did not complete within %0d cycles", num_queries * 600 + 5000);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/interp_pkg.sv
source/sample_ram.sv
source/seq_multiplier.sv
source/seq_divider.sv
source/interp_fsm.sv
source/interp_unit.sv
source/interp_apb_regs.sv
source/interp_top.sv
dv/interp_checker.sv
dv/interp_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module interp_tb -Mdir obj_dir -o sim_interp

./obj_dir/sim_interp | tee sim.log

grep -q "^=== PASS ===$" sim.log
